// ==== verilog/vic20_pkg.sv ====
`default_nettype none

package vic20_pkg;

   // ========================================
   // Bus widths and types
   // ========================================
   localparam int ADDR_W = 16;              // CPU address bus
   localparam int DATA_W = 8;               // CPU data bus

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // CPU speed select
   typedef enum logic [1:0] {
      TURBO_1MHZ = 2'd0,
      TURBO_2MHZ = 2'd1,
      TURBO_4MHZ = 2'd2
   } turbo_t;

   localparam int CLKDIV_PERIOD = 25;       // 25 MHz down to the 1 MHz frame

   // ========================================
   // Address map
   // ========================================
   localparam logic [11:0] VIC_REG_PAGE = 12'h900;   // $9000-$900F
   localparam addr_t JOY_ADDR_A   = 16'h9111;        // VIA1 port A
   localparam addr_t JOY_ADDR_B   = 16'h911F;        // VIA1 port A, no handshake
   localparam addr_t KBD_COL_ADDR = 16'h9120;        // VIA2 port B
   localparam addr_t KBD_ROW_ADDR = 16'h9121;        // VIA2 port A

   // ========================================
   // Video field reset values
   // ========================================
   localparam addr_t RST_SCREEN_ADDR    = 16'h1E00;
   localparam addr_t RST_CHAR_ROM_ADDR  = 16'h8000;
   localparam addr_t RST_COLOR_RAM_ADDR = 16'h9400;

   localparam logic [6:0] RST_XORIGIN = 7'd12;
   localparam logic [7:0] RST_YORIGIN = 8'd38;
   localparam logic [6:0] RST_COLS    = 7'd22;       // Standard 22x23 text screen
   localparam logic [6:0] RST_ROWS    = 7'd23;

endpackage

`default_nettype wire

// ==== verilog/vic_clken_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_clken_gen #(
   parameter vic20_pkg::turbo_t TURBO = vic20_pkg::TURBO_1MHZ
) (
   input  wire  clk25,
   input  wire  pwr_up_reset_n,
   input  wire  i_halt,          // Stops the CPU and the VIAs
   output logic o_cpu_clken,
   output logic o_via1_clken,
   output logic o_via4_clken
);
   import vic20_pkg::*;

   localparam int CNT_W = $clog2(CLKDIV_PERIOD);

   logic [CNT_W-1:0] cnt;        // 0 to 24
   logic             low_half;   // Strobes only in counts 0-15
   logic             cpu_nxt;
   logic             via4_nxt;

   assign low_half = cnt < CNT_W'(16);

   // Strobe pattern by speed
   always_comb begin
      case (TURBO)
         TURBO_1MHZ: begin
            cpu_nxt  = (cnt == '0);                      // Count 0 only
            via4_nxt = low_half && (cnt[1:0] == 2'b00);  // 0, 4, 8, 12
         end
         TURBO_2MHZ: begin
            cpu_nxt  = low_half && (cnt[2:0] == 3'b000); // 0, 8
            via4_nxt = low_half && !cnt[0];              // Every 2nd
         end
         default: begin
            cpu_nxt  = low_half && (cnt[1:0] == 2'b00);  // 0, 4, 8, 12
            via4_nxt = low_half;                         // Every count
         end
      endcase
   end

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         cnt          <= '0;
         o_cpu_clken  <= 1'b0;
         o_via1_clken <= 1'b0;
         o_via4_clken <= 1'b0;
      end else begin
         cnt          <= (cnt == CNT_W'(CLKDIV_PERIOD - 1)) ? '0 : cnt + 1'b1;
         o_cpu_clken  <= cpu_nxt && !i_halt;
         o_via1_clken <= cpu_nxt && !i_halt;   // VIA phase 2 tracks the CPU
         o_via4_clken <= via4_nxt && !i_halt;
      end
   end

   // Every CPU strobe lands on a VIA4 strobe
   a_cpu_in_via4: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      o_cpu_clken |-> o_via4_clken);

   // Halt silences all strobes one cycle later
   a_halt_quiet: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      $past(i_halt) |-> !(o_cpu_clken || o_via1_clken || o_via4_clken));

endmodule

`default_nettype wire

// ==== verilog/vic_reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_reg_file (
   input  wire                      clk25,
   input  wire                      pwr_up_reset_n,
   input  wire vic20_pkg::addr_t    i_addr,
   input  wire vic20_pkg::data_t    i_wdata,
   input  wire                      i_wr,
   // Video fields
   output vic20_pkg::addr_t         o_screen_addr,
   output vic20_pkg::addr_t         o_char_rom_addr,
   output vic20_pkg::addr_t         o_color_ram_addr,
   output logic [6:0]               o_xorigin,
   output logic [7:0]               o_yorigin,
   output logic [6:0]               o_cols,
   output logic [6:0]               o_rows,
   output logic                     o_chars8x16,
   output logic [2:0]               o_border_color,
   output logic [3:0]               o_back_color,
   output logic [3:0]               o_aux_color,
   output logic                     o_inverted,
   // Sound fields
   output vic20_pkg::data_t         o_bass,
   output vic20_pkg::data_t         o_alto,
   output vic20_pkg::data_t         o_soprano,
   output logic [3:0]               o_volume,
   output vic20_pkg::data_t         o_reg_rdata   // Combinational readback
);
   import vic20_pkg::*;

   data_t noise;      // Noise voice is gone, the byte still reads back
   logic  reg_wr;

   assign reg_wr = i_wr && (i_addr[15:4] == VIC_REG_PAGE);

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_screen_addr    <= RST_SCREEN_ADDR;
         o_char_rom_addr  <= RST_CHAR_ROM_ADDR;
         o_color_ram_addr <= RST_COLOR_RAM_ADDR;
         o_xorigin        <= RST_XORIGIN;
         o_yorigin        <= RST_YORIGIN;
         o_cols           <= RST_COLS;
         o_rows           <= RST_ROWS;
         o_chars8x16      <= 1'b0;
         o_border_color   <= '0;
         o_back_color     <= '0;
         o_aux_color      <= '0;
         o_inverted       <= 1'b0;
         o_bass           <= '0;   // Voices off
         o_alto           <= '0;
         o_soprano        <= '0;
         noise            <= '0;
         o_volume         <= '0;
      end else if (reg_wr) begin
         case (i_addr[3:0])
            4'h0: o_xorigin <= i_wdata[6:0];
            4'h1: o_yorigin <= i_wdata;
            4'h2: begin
               o_screen_addr[9]    <= i_wdata[7];   // Extra address bit
               o_color_ram_addr[9] <= i_wdata[7];
               o_cols              <= i_wdata[6:0];
            end
            4'h3: begin
               o_rows      <= i_wdata[6:0];
               o_chars8x16 <= i_wdata[0];           // Shares bit 0 with rows
            end
            4'h5: begin
               o_char_rom_addr[15]    <= ~i_wdata[3]; // A15 is active low here
               o_char_rom_addr[12:10] <= i_wdata[2:0];
               o_screen_addr[15]      <= ~i_wdata[7];
               o_screen_addr[12:10]   <= i_wdata[6:4];
            end
            4'hA: o_bass    <= i_wdata;
            4'hB: o_alto    <= i_wdata;
            4'hC: o_soprano <= i_wdata;
            4'hD: noise     <= i_wdata;
            4'hE: begin
               o_aux_color <= i_wdata[7:4];
               o_volume    <= i_wdata[3:0];
            end
            4'hF: begin
               o_back_color   <= i_wdata[7:4];
               o_inverted     <= i_wdata[3];
               o_border_color <= i_wdata[2:0];
            end
            default: ;   // 4, 6-9 hold nothing
         endcase
      end
   end

   // Readback rebuilt from the fields
   always_comb begin
      case (i_addr[3:0])
         4'h0: o_reg_rdata = {1'b0, o_xorigin};
         4'h1: o_reg_rdata = o_yorigin;
         4'h2: o_reg_rdata = {o_screen_addr[9], o_cols};
         4'h3: o_reg_rdata = {1'b0, o_rows};
         4'h5: o_reg_rdata = {~o_screen_addr[15], o_screen_addr[12:10],
                              ~o_char_rom_addr[15], o_char_rom_addr[12:10]};
         4'hA: o_reg_rdata = o_bass;
         4'hB: o_reg_rdata = o_alto;
         4'hC: o_reg_rdata = o_soprano;
         4'hD: o_reg_rdata = noise;
         4'hE: o_reg_rdata = {o_aux_color, o_volume};
         4'hF: o_reg_rdata = {o_back_color, o_inverted, o_border_color};
         default: o_reg_rdata = '0;
      endcase
   end

   // Write strobe from the bus must be clean once running
   a_wr_known: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      !$isunknown(i_wr));

endmodule

`default_nettype wire

// ==== verilog/vic_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_bus_decode (
   input  wire                      clk25,
   input  wire                      pwr_up_reset_n,
   input  wire vic20_pkg::addr_t    i_addr,
   input  wire vic20_pkg::data_t    i_wdata,
   input  wire                      i_wr,
   input  wire [6:0]                i_btn,        // Active high
   input  wire [7:0]                i_kbd_row,
   input  wire vic20_pkg::data_t    i_ram_rdata,
   input  wire vic20_pkg::data_t    i_reg_rdata,
   output vic20_pkg::data_t         o_rdata,      // One cycle after the address
   output logic                     o_ram_we,
   output vic20_pkg::data_t         o_kbd_col
);
   import vic20_pkg::*;

   logic  rom_region;
   data_t joy_byte;
   data_t row_byte;

   // ROM at $8xxx and $Cxxx-$Fxxx
   assign rom_region = (i_addr[15:12] == 4'h8) || (i_addr[15:14] == 2'b11);
   assign o_ram_we   = i_wr && !rom_region;

   // Joystick lines pulled up, pressed reads 0
   assign joy_byte = {2'b11, ~i_btn[1], ~i_btn[5], ~i_btn[4], ~i_btn[3], 2'b11};
   assign row_byte = {i_kbd_row[0], i_kbd_row[6:1], i_kbd_row[7]};   // Matrix wiring

   // Keyboard column latch
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_kbd_col <= 8'hFF;   // No column driven
      end else if (i_wr && (i_addr == KBD_COL_ADDR)) begin
         o_kbd_col <= i_wdata;
      end
   end

   // ========================================
   // Registered read mux
   // ========================================
   always_ff @(posedge clk25) begin
      if (i_addr[15:4] == VIC_REG_PAGE) begin
         o_rdata <= i_reg_rdata;
      end else if ((i_addr == JOY_ADDR_A) || (i_addr == JOY_ADDR_B)) begin
         o_rdata <= joy_byte;
      end else if (i_addr == KBD_COL_ADDR) begin
         o_rdata <= o_kbd_col;
      end else if (i_addr == KBD_ROW_ADDR) begin
         o_rdata <= row_byte;
      end else begin
         o_rdata <= i_ram_rdata;   // Everything else is RAM or ROM
      end
   end

endmodule

`default_nettype wire

// ==== verilog/vic_sound_voice.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_sound_voice #(
   parameter int OCTAVE_SHIFT = 0   // Tick every 2^OCTAVE_SHIFT strobes
) (
   input  wire                      clk25,
   input  wire                      pwr_up_reset_n,
   input  wire                      i_tick_en,   // VIA4 strobe
   input  wire vic20_pkg::data_t    i_freq,      // Bit 7 enables
   output logic                     o_wave
);
   localparam int PRE_W = (OCTAVE_SHIFT > 0) ? OCTAVE_SHIFT : 1;
   localparam logic [PRE_W-1:0] PRE_MAX = PRE_W'((2 ** OCTAVE_SHIFT) - 1);

   logic [PRE_W-1:0] pre_cnt;   // Octave prescaler
   logic [6:0]       cnt;       // Half-period counter
   logic             tick;

   assign tick = i_tick_en && (pre_cnt == PRE_MAX);

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         pre_cnt <= '0;
         cnt     <= '0;
         o_wave  <= 1'b0;
      end else begin
         if (i_tick_en) begin
            pre_cnt <= (pre_cnt == PRE_MAX) ? '0 : pre_cnt + 1'b1;
         end
         if (!i_freq[7]) begin
            cnt    <= '0;   // Voice off, park low
            o_wave <= 1'b0;
         end else if (tick) begin
            if (cnt == 7'd127) begin
               cnt    <= i_freq[6:0];   // Reload, half period done
               o_wave <= ~o_wave;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

   // Counter either climbs or reloads, never wraps past 127
   a_cnt_bound: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      (i_freq[7] && tick) |=> (cnt > $past(cnt)) || (cnt == $past(i_freq[6:0])));

endmodule

`default_nettype wire

// ==== verilog/vic_sound.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_sound (
   input  wire                      clk25,
   input  wire                      pwr_up_reset_n,
   input  wire                      i_via4_clken,
   input  wire vic20_pkg::data_t    i_bass,
   input  wire vic20_pkg::data_t    i_alto,
   input  wire vic20_pkg::data_t    i_soprano,
   input  wire [3:0]                i_volume,
   output logic [3:0]               o_audio
);
   logic       bass_wave;
   logic       alto_wave;
   logic       soprano_wave;
   logic [1:0] n_high;   // Voices currently high
   logic [5:0] level;    // Up to 15 x 3

   // Bass is two octaves down from soprano
   vic_sound_voice #(.OCTAVE_SHIFT(2)) i_bass_voice (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_tick_en      (i_via4_clken),
      .i_freq         (i_bass),
      .o_wave         (bass_wave)
   );

   vic_sound_voice #(.OCTAVE_SHIFT(1)) i_alto_voice (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_tick_en      (i_via4_clken),
      .i_freq         (i_alto),
      .o_wave         (alto_wave)
   );

   vic_sound_voice #(.OCTAVE_SHIFT(0)) i_soprano_voice (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_tick_en      (i_via4_clken),
      .i_freq         (i_soprano),
      .o_wave         (soprano_wave)
   );

   assign n_high = {1'b0, bass_wave} + {1'b0, alto_wave} + {1'b0, soprano_wave};
   assign level  = {2'b00, i_volume} * {4'b0000, n_high};

   // Saturating mixer
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_audio <= '0;
      end else begin
         o_audio <= (level > 6'd15) ? 4'hF : level[3:0];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/vic20_periph.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic20_periph #(
   parameter vic20_pkg::turbo_t TURBO = vic20_pkg::TURBO_1MHZ
) (
   input  wire                      clk25,
   input  wire                      pwr_up_reset_n,
   // CPU side bus
   input  wire vic20_pkg::addr_t    i_addr,
   input  wire vic20_pkg::data_t    i_wdata,
   input  wire                      i_wr,
   input  wire                      i_halt,
   input  wire [6:0]                i_btn,
   input  wire [7:0]                i_kbd_row,
   input  wire vic20_pkg::data_t    i_ram_rdata,
   // Clock enables
   output wire                      o_cpu_clken,
   output wire                      o_via1_clken,
   output wire                      o_via4_clken,
   // Bus results
   output vic20_pkg::data_t         o_rdata,
   output wire                      o_ram_we,
   output vic20_pkg::data_t         o_kbd_col,
   output wire [3:0]                o_audio,
   // Video fields
   output vic20_pkg::addr_t         o_screen_addr,
   output vic20_pkg::addr_t         o_char_rom_addr,
   output vic20_pkg::addr_t         o_color_ram_addr,
   output wire [6:0]                o_xorigin,
   output wire [7:0]                o_yorigin,
   output wire [6:0]                o_cols,
   output wire [6:0]                o_rows,
   output wire                      o_chars8x16,
   output wire [2:0]                o_border_color,
   output wire [3:0]                o_back_color,
   output wire [3:0]                o_aux_color,
   output wire                      o_inverted
);
   import vic20_pkg::*;

   data_t      reg_rdata;   // Register bank readback
   data_t      bass;
   data_t      alto;
   data_t      soprano;
   logic [3:0] volume;

   // ========================================
   // Clock enables
   // ========================================
   vic_clken_gen #(.TURBO(TURBO)) i_clken_gen (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_halt         (i_halt),
      .o_cpu_clken    (o_cpu_clken),
      .o_via1_clken   (o_via1_clken),
      .o_via4_clken   (o_via4_clken)
   );

   vic_reg_file i_reg_file (
      .clk25            (clk25),
      .pwr_up_reset_n   (pwr_up_reset_n),
      .i_addr           (i_addr),
      .i_wdata          (i_wdata),
      .i_wr             (i_wr),
      .o_screen_addr    (o_screen_addr),
      .o_char_rom_addr  (o_char_rom_addr),
      .o_color_ram_addr (o_color_ram_addr),
      .o_xorigin        (o_xorigin),
      .o_yorigin        (o_yorigin),
      .o_cols           (o_cols),
      .o_rows           (o_rows),
      .o_chars8x16      (o_chars8x16),
      .o_border_color   (o_border_color),
      .o_back_color     (o_back_color),
      .o_aux_color      (o_aux_color),
      .o_inverted       (o_inverted),
      .o_bass           (bass),
      .o_alto           (alto),
      .o_soprano        (soprano),
      .o_volume         (volume),
      .o_reg_rdata      (reg_rdata)
   );

   vic_bus_decode i_bus_decode (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_addr         (i_addr),
      .i_wdata        (i_wdata),
      .i_wr           (i_wr),
      .i_btn          (i_btn),
      .i_kbd_row      (i_kbd_row),
      .i_ram_rdata    (i_ram_rdata),
      .i_reg_rdata    (reg_rdata),
      .o_rdata        (o_rdata),
      .o_ram_we       (o_ram_we),
      .o_kbd_col      (o_kbd_col)
   );

   // ========================================
   // Sound
   // ========================================
   vic_sound i_sound (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_via4_clken   (o_via4_clken),   // Voices run off the VIA4 rate
      .i_bass         (bass),
      .i_alto         (alto),
      .i_soprano      (soprano),
      .i_volume       (volume),
      .o_audio        (o_audio)
   );

endmodule

`default_nettype wire

// ==== dv/tb_vic20_periph.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_vic20_periph;
   import vic20_pkg::*;

   // DUT inputs
   logic        clk25;
   logic        pwr_up_reset_n;
   logic [15:0] i_addr;
   logic [7:0]  i_wdata;
   logic        i_wr;
   logic        i_halt;
   logic [6:0]  i_btn;
   logic [7:0]  i_kbd_row;
   logic [7:0]  i_ram_rdata;

   // DUT outputs
   logic        o_cpu_clken;
   logic        o_via1_clken;
   logic        o_via4_clken;
   logic [7:0]  o_rdata;
   logic        o_ram_we;
   logic [7:0]  o_kbd_col;
   logic [3:0]  o_audio;
   logic [15:0] o_screen_addr;
   logic [15:0] o_char_rom_addr;
   logic [15:0] o_color_ram_addr;
   logic [6:0]  o_xorigin;
   logic [7:0]  o_yorigin;
   logic [6:0]  o_cols;
   logic [6:0]  o_rows;
   logic        o_chars8x16;
   logic [2:0]  o_border_color;
   logic [3:0]  o_back_color;
   logic [3:0]  o_aux_color;
   logic        o_inverted;

   // Expected field values
   logic [15:0] exp_screen;
   logic [15:0] exp_char_rom;
   logic [15:0] exp_color_ram;
   logic [6:0]  exp_xorigin;
   logic [7:0]  exp_yorigin;
   logic [6:0]  exp_cols;
   logic [6:0]  exp_rows;
   logic        exp_chars8x16;
   logic [2:0]  exp_border;
   logic [3:0]  exp_back;
   logic [3:0]  exp_aux;
   logic        exp_inverted;
   logic [7:0]  exp_kbd_col;

   // Parsed stimulus, one entry per operation
   logic [7:0]  op_q[$];
   logic [31:0] a_q[$];
   logic [31:0] b_q[$];
   logic [31:0] c_q[$];

   int errors      = 0;
   int cycles      = 0;
   int cycle_limit = 0;   // 0 until the file is read

   vic20_periph #(.TURBO(TURBO_1MHZ)) i_vic20_periph (
      .clk25            (clk25),
      .pwr_up_reset_n   (pwr_up_reset_n),
      .i_addr           (i_addr),
      .i_wdata          (i_wdata),
      .i_wr             (i_wr),
      .i_halt           (i_halt),
      .i_btn            (i_btn),
      .i_kbd_row        (i_kbd_row),
      .i_ram_rdata      (i_ram_rdata),
      .o_cpu_clken      (o_cpu_clken),
      .o_via1_clken     (o_via1_clken),
      .o_via4_clken     (o_via4_clken),
      .o_rdata          (o_rdata),
      .o_ram_we         (o_ram_we),
      .o_kbd_col        (o_kbd_col),
      .o_audio          (o_audio),
      .o_screen_addr    (o_screen_addr),
      .o_char_rom_addr  (o_char_rom_addr),
      .o_color_ram_addr (o_color_ram_addr),
      .o_xorigin        (o_xorigin),
      .o_yorigin        (o_yorigin),
      .o_cols           (o_cols),
      .o_rows           (o_rows),
      .o_chars8x16      (o_chars8x16),
      .o_border_color   (o_border_color),
      .o_back_color     (o_back_color),
      .o_aux_color      (o_aux_color),
      .o_inverted       (o_inverted)
   );

   initial begin
      clk25 = 1'b0;
      forever #4 clk25 = ~clk25;   // 125 MHz sim clock, 8 ns
   end

   // Watchdog
   always @(posedge clk25) begin
      cycles = cycles + 1;
      if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("Fail at %t: %s = %0d (0x%0h), expected %0d (0x%0h)",
               $time, name, got, got, exp, exp);
   endtask

   // ========================================
   // Reference model of the register bank
   // ========================================
   task automatic update_model(input logic [15:0] addr, input logic [7:0] data);
      if (addr[15:4] == 12'h900) begin
         case (addr[3:0])
            4'h0: exp_xorigin = data[6:0];
            4'h1: exp_yorigin = data;
            4'h2: begin
               exp_screen[9]    = data[7];   // Shared extra address bit
               exp_color_ram[9] = data[7];
               exp_cols         = data[6:0];
            end
            4'h3: begin
               exp_rows      = data[6:0];
               exp_chars8x16 = data[0];
            end
            4'h5: begin
               exp_char_rom[15]    = ~data[3];
               exp_char_rom[12:10] = data[2:0];
               exp_screen[15]      = ~data[7];
               exp_screen[12:10]   = data[6:4];
            end
            4'hE: exp_aux = data[7:4];
            4'hF: begin
               exp_back     = data[7:4];
               exp_inverted = data[3];
               exp_border   = data[2:0];
            end
            default: ;   // Sound, noise and empty slots
         endcase
      end
      if (addr == 16'h9120) begin
         exp_kbd_col = data;
      end
   endtask

   task automatic check_fields();
      if (o_screen_addr !== exp_screen) begin
         report_mismatch("o_screen_addr", o_screen_addr, exp_screen);
      end
      if (o_char_rom_addr !== exp_char_rom) begin
         report_mismatch("o_char_rom_addr", o_char_rom_addr, exp_char_rom);
      end
      if (o_color_ram_addr !== exp_color_ram) begin
         report_mismatch("o_color_ram_addr", o_color_ram_addr, exp_color_ram);
      end
      if (o_xorigin !== exp_xorigin) report_mismatch("o_xorigin", o_xorigin, exp_xorigin);
      if (o_yorigin !== exp_yorigin) report_mismatch("o_yorigin", o_yorigin, exp_yorigin);
      if (o_cols !== exp_cols) report_mismatch("o_cols", o_cols, exp_cols);
      if (o_rows !== exp_rows) report_mismatch("o_rows", o_rows, exp_rows);
      if (o_chars8x16 !== exp_chars8x16) begin
         report_mismatch("o_chars8x16", o_chars8x16, exp_chars8x16);
      end
      if (o_border_color !== exp_border) begin
         report_mismatch("o_border_color", o_border_color, exp_border);
      end
      if (o_back_color !== exp_back) report_mismatch("o_back_color", o_back_color, exp_back);
      if (o_aux_color !== exp_aux) report_mismatch("o_aux_color", o_aux_color, exp_aux);
      if (o_inverted !== exp_inverted) report_mismatch("o_inverted", o_inverted, exp_inverted);
      if (o_kbd_col !== exp_kbd_col) report_mismatch("o_kbd_col", o_kbd_col, exp_kbd_col);
   endtask

   // ========================================
   // Bus operations, called 1 ns after an edge
   // ========================================
   task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
      logic exp_we;
      i_addr  = addr;
      i_wdata = data;
      i_wr    = 1'b1;
      exp_we  = !((addr[15:12] == 4'h8) || (addr[15:12] >= 4'hC));   // ROM blocks
      #2;
      if (o_ram_we !== exp_we) report_mismatch("o_ram_we", o_ram_we, exp_we);
      @(posedge clk25);
      #1;
      i_wr = 1'b0;
      update_model(addr, data);
      check_fields();
   endtask

   task automatic read_bus(input logic [15:0] addr, input logic [7:0] exp);
      i_addr = addr;
      i_wr   = 1'b0;
      @(posedge clk25);
      #1;   // Registered read data now valid
      if (o_rdata !== exp) report_mismatch("o_rdata", o_rdata, exp);
   endtask

   // Strobe counts over a 250 cycle window
   task automatic count_enables(input logic halted);
      int n_cpu;
      int n_via1;
      int n_via4;
      int exp_cpu;
      int exp_via4;
      n_cpu    = 0;
      n_via1   = 0;
      n_via4   = 0;
      exp_cpu  = halted ? 0 : 250 / 25;       // One per divider period
      exp_via4 = halted ? 0 : 4 * 250 / 25;   // Four per divider period
      i_halt   = halted;
      if (halted) begin
         @(posedge clk25);   // Strobes follow halt one cycle later
         #1;
      end
      repeat (250) begin
         @(posedge clk25);
         #1;
         if (o_cpu_clken === 1'b1) n_cpu++;
         if (o_via1_clken === 1'b1) n_via1++;   // VIA1 runs at the CPU rate
         if (o_via4_clken === 1'b1) n_via4++;
      end
      if (n_cpu != exp_cpu) report_mismatch("o_cpu_clken pulses", n_cpu, exp_cpu);
      if (n_via1 != exp_cpu) report_mismatch("o_via1_clken pulses", n_via1, exp_cpu);
      if (n_via4 != exp_via4) report_mismatch("o_via4_clken pulses", n_via4, exp_via4);
      i_halt = 1'b0;
   endtask

   // Soprano alone, then count level changes on o_audio
   task automatic sound_window(input logic [7:0] freq, input logic [3:0] vol);
      int         trans;
      int         exp_trans;
      int         f;
      logic [3:0] hi;
      logic [3:0] prev;
      f  = freq[6:0];
      hi = freq[7] ? vol : 4'h0;
      write_bus(16'h900A, 8'h00);   // Bass off
      write_bus(16'h900B, 8'h00);   // Alto off
      write_bus(16'h900E, {4'h0, vol});
      write_bus(16'h900C, freq);
      if (freq[7]) begin
         exp_trans = (4000 * 40) / (250 * (128 - f));
         while (o_audio !== vol) begin   // First half period from a zero count
            @(posedge clk25);
            #1;
         end
      end else begin
         exp_trans = 0;
         repeat (3) begin   // Field, voice, mixer
            @(posedge clk25);
            #1;
         end
      end
      trans = 0;
      prev  = o_audio;
      repeat (4000) begin
         @(posedge clk25);
         #1;
         if ((o_audio !== 4'h0) && (o_audio !== hi)) begin
            errors++;
            $display("Fail at %t: o_audio = %0d, expected 0 or %0d", $time, o_audio, hi);
         end
         if (o_audio !== prev) trans++;
         prev = o_audio;
      end
      if ((trans > exp_trans + 1) || (trans + 1 < exp_trans)) begin
         report_mismatch("o_audio transitions", trans, exp_trans);
      end
   endtask

   initial begin
      int          fd;
      int          ch;
      int          n;
      int          i;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      $timeformat(-9, 0, " ns", 0);
      pwr_up_reset_n = 1'b0;
      i_addr         = '0;
      i_wdata        = '0;
      i_wr           = 1'b0;
      i_halt         = 1'b0;
      i_btn          = '0;
      i_kbd_row      = '0;
      i_ram_rdata    = '0;
      exp_screen     = 16'h1E00;
      exp_char_rom   = 16'h8000;
      exp_color_ram  = 16'h9400;
      exp_xorigin    = 7'd12;
      exp_yorigin    = 8'd38;
      exp_cols       = 7'd22;   // 22 x 23 text screen
      exp_rows       = 7'd23;
      exp_chars8x16  = 1'b0;
      exp_border     = '0;
      exp_back       = '0;
      exp_aux        = '0;
      exp_inverted   = 1'b0;
      exp_kbd_col    = 8'hFF;   // No column selected
      fd = $fopen("dv/vic20_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file dv/vic20_stim.txt");
         $display("Testbench failed");
         $finish;
      end else begin
         while ($fscanf(fd, " %c", op) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            n = 0;
            case (op)
               "#": begin   // Skip the rest of a comment line
                  ch = $fgetc(fd);
                  while ((ch != "\n") && (ch != -1)) begin
                     ch = $fgetc(fd);
                  end
               end
               "W", "R", "S": n = $fscanf(fd, " %h %h", a, b);
               "K": n = $fscanf(fd, " %h %h %h", a, b, c);
               "E", "H": n = 0;
               default: begin
                  errors++;
                  $display("Unknown opcode %c in the stimulus file", op);
               end
            endcase
            if (((op == "W") || (op == "R") || (op == "S")) && (n != 2)) begin
               errors++;
               $display("Stimulus line with opcode %c has missing operands", op);
            end else if ((op == "K") && (n != 3)) begin
               errors++;
               $display("Stimulus line with opcode K has missing operands");
            end else if ((op == "W") || (op == "R") || (op == "S") || (op == "K") ||
                         (op == "E") || (op == "H")) begin
               op_q.push_back(op);
               a_q.push_back(a);
               b_q.push_back(b);
               c_q.push_back(c);
            end
         end
         $fclose(fd);
         cycle_limit = op_q.size() * 300 + 2000;

         // Reset for 4 cycles
         repeat (4) @(posedge clk25);
         #1;
         pwr_up_reset_n = 1'b1;
         check_fields();
         if (o_audio !== 4'h0) report_mismatch("o_audio", o_audio, 0);

         for (i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
               "W": write_bus(a_q[i][15:0], b_q[i][7:0]);
               "R": read_bus(a_q[i][15:0], b_q[i][7:0]);
               "K": begin
                  i_kbd_row   = a_q[i][7:0];
                  i_btn       = b_q[i][6:0];
                  i_ram_rdata = c_q[i][7:0];
               end
               "E": count_enables(1'b0);
               "H": count_enables(1'b1);
               "S": sound_window(a_q[i][7:0], b_q[i][3:0]);
               default: ;
            endcase
         end

         $display("Run complete: %0d operations, %0d errors", op_q.size(), errors);
         if (errors == 0) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== dv/vic20_stim.txt ====
# Columns: opcode, then hex operands. W addr data | R addr expected | K row btn ram
# E clock-enable window | H halt window | S soprano_freq volume
W 9000 8C
R 9000 0C
W 9001 40
R 9001 40
W 9002 97
R 9002 97
W 9003 AF
R 9003 2F
W 9004 55
R 9004 00
W 9005 C2
R 9005 C2
W 9008 33
R 9008 00
W 900A 12
R 900A 12
W 900B 34
R 900B 34
W 900C 56
R 900C 56
W 900D 9E
R 900D 9E
W 900E A3
R 900E A3
W 900F 5B
R 900F 5B
W 9120 E7
R 9120 E7
K 35 32 5A
R 9121 B4
R 9111 C7
R 911F C7
R 2000 5A
W 1000 77
W C000 77
W 8000 11
E
H
E
S 00 5
S F0 9

// ==== sources.f ====
verilog/vic20_pkg.sv
verilog/vic_clken_gen.sv
verilog/vic_reg_file.sv
verilog/vic_bus_decode.sv
verilog/vic_sound_voice.sv
verilog/vic_sound.sv
verilog/vic20_periph.sv
dv/tb_vic20_periph.sv
